//--- Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decode_stage_tb
RTL_TOP   ?= decode_stage
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

SOURCES   := $(shell grep -v '^+' $(FILELIST)) rtl/decode_params.svh
RTL_SRCS  := $(filter rtl/%,$(shell grep -v '^+' $(FILELIST)))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -q "^TEST RESULT: PASS$$" $(LOG) || \
		(echo "simulation did not pass, see $(LOG)" ; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+rtl --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/decode_stage_tb.sv
// simulation top of the decode stage that checks LFSR stimulus against a reference model
`timescale 1ns/100ps
`include "decode_params.svh"

module decode_stage_tb
    import rv_decode_pkg::*;
();

    localparam int MAX_CYCLES = 6000;
    localparam int RESET_WAIT = 20;

    logic        clk;
    logic        reset;
    instr_t      instr;
    xlen_t       pc;
    reg_write_t  wb;
    decode_out_t stage_out;

    // model state
    xlen_t       model_regs [`NUM_REGS];
    decode_out_t exp_q [$];
    string       name_q [$];
    logic [31:0] lfsr_state;
    int          cycle_count = 0;

    // the thirteen legal opcodes picked by index
    opcode_e legal_opc [13] = '{OPC_OP, OPC_OP_32, OPC_JALR, OPC_LOAD, OPC_OP_IMM,
                                OPC_OP_IMM_32, OPC_STORE, OPC_BRANCH, OPC_LUI,
                                OPC_AUIPC, OPC_JAL, OPC_MISC_MEM, OPC_SYSTEM};

    decode_stage UUT (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .pc    (pc),
        .wb    (wb),
        .out   (stage_out)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // reset held for 8 rising edges
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #2 reset = 1'b0;
    end

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // watchdog over the whole run
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYCLES)
            fail_stop("simulation ran past its cycle limit without finishing");
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit with the newest bit at the bottom
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic is_legal_opcode(input logic [6:0] o);
        case (o)
            OPC_OP, OPC_OP_32, OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM_32,
            OPC_STORE, OPC_BRANCH, OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_MISC_MEM,
            OPC_SYSTEM: return 1'b1;
            default:    return 1'b0;
        endcase
    endfunction

    // random word with about one in eight illegal when allowed
    function automatic instr_t rand_word(input logic allow_illegal);
        logic [63:0] r;
        logic [24:0] upper;
        logic [2:0]  pick;
        logic [6:0]  opc;
        logic [3:0]  sel;
        r = take_bits(25);
        upper = r[24:0];
        r = take_bits(3);
        pick = r[2:0];
        if (allow_illegal && pick == 3'd0) begin
            r = take_bits(7);
            opc = r[6:0];
            // walk off any legal code
            for (int i = 0; i < 128 && is_legal_opcode(opc); i++)
                opc = opc + 7'd1;
        end else begin
            r = take_bits(8);
            sel = 4'(r[7:0] % 8'd13);
            opc = legal_opc[sel];
        end
        return {upper, opc};
    endfunction

    // R-format word reading a and b
    function automatic instr_t r_read_word(input reg_idx_t a, input reg_idx_t b);
        logic [63:0] r;
        r = take_bits(15);
        return {r[14:8], b, a, r[7:5], r[4:0], OPC_OP};
    endfunction

    function automatic reg_write_t make_write(input logic en, input reg_idx_t idx,
                                              input xlen_t data);
        reg_write_t w;
        w.en   = en;
        w.idx  = idx;
        w.data = data;
        return w;
    endfunction

    // reference decode straight from the RV64I encoding tables
    function automatic decoded_t model_decode(input instr_t w);
        decoded_t    d;
        logic [11:0] i12;
        logic [11:0] s12;
        logic [12:0] b13;
        logic [20:0] j21;
        d   = '0;
        i12 = w[31:20];
        s12 = {w[31:25], w[11:7]};
        b13 = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        j21 = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        case (w[6:0])
            OPC_OP, OPC_OP_32: begin
                d.fmt = FMT_R;
                d.rs1 = w[19:15];
                d.rs2 = w[24:20];
                d.rd  = w[11:7];
            end
            OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM_32, OPC_MISC_MEM, OPC_SYSTEM: begin
                d.fmt = FMT_I;
                d.rs1 = w[19:15];
                d.rd  = w[11:7];
                d.imm = xlen_t'($signed(i12));
            end
            OPC_STORE: begin
                d.fmt = FMT_S;
                d.rs1 = w[19:15];
                d.rs2 = w[24:20];
                d.imm = xlen_t'($signed(s12));
            end
            OPC_BRANCH: begin
                d.fmt = FMT_B;
                d.rs1 = w[19:15];
                d.rs2 = w[24:20];
                d.imm = xlen_t'($signed(b13));
            end
            OPC_LUI, OPC_AUIPC: begin
                d.fmt = FMT_U;
                d.rd  = w[11:7];
                d.imm = xlen_t'($signed({w[31:12], 12'h000}));
            end
            OPC_JAL: begin
                d.fmt = FMT_J;
                d.rd  = w[11:7];
                d.imm = xlen_t'($signed(j21));
            end
            default: d.illegal = 1'b1;
        endcase
        // U and J carry no funct3
        if (d.fmt == FMT_U || d.fmt == FMT_J)
            d.opfunc = {3'b000, w[6:0]};
        else if (d.fmt != FMT_NONE)
            d.opfunc = {w[14:12], w[6:0]};
        return d;
    endfunction

    task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp)
            fail_stop($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_instr(input string name, input instr_t exp, input instr_t act);
        if (act !== exp)
            fail_stop($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp)
            fail_stop($sformatf("[FAIL] %s: expected x%0d, actual x%0d", name, exp, act));
    endtask

    task automatic check_opfunc(input string name, input opfunc_t exp, input opfunc_t act);
        if (act !== exp)
            fail_stop($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_fmt(input string name, input instr_fmt_e exp, input instr_fmt_e act);
        if (act !== exp)
            fail_stop($sformatf("[FAIL] %s: expected %s (%0d), actual %s (%0d)",
                                name, exp.name(), exp, act.name(), act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_stop($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
    endtask

    // every field of the stage output
    task automatic check_out(input string n, input decode_out_t e);
        check_xlen({n, " pc"}, e.pc, stage_out.pc);
        check_instr({n, " instr"}, e.instr, stage_out.instr);
        check_fmt({n, " fmt"}, e.dec.fmt, stage_out.dec.fmt);
        check_opfunc({n, " opfunc"}, e.dec.opfunc, stage_out.dec.opfunc);
        check_idx({n, " rs1"}, e.dec.rs1, stage_out.dec.rs1);
        check_idx({n, " rs2"}, e.dec.rs2, stage_out.dec.rs2);
        check_idx({n, " rd"}, e.dec.rd, stage_out.dec.rd);
        check_xlen({n, " imm"}, e.dec.imm, stage_out.dec.imm);
        check_flag({n, " illegal"}, e.dec.illegal, stage_out.dec.illegal);
        check_xlen({n, " rs1_data"}, e.rs1_data, stage_out.rs1_data);
        check_xlen({n, " rs2_data"}, e.rs2_data, stage_out.rs2_data);
    endtask

    task automatic compare_pending();
        decode_out_t e;
        string       n;
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            n = name_q.pop_front();
            check_out(n, e);
        end
    endtask

    // one instruction per cycle with the previous one checked first
    task automatic drive_cycle(input string name, input instr_t w, input reg_write_t wr);
        decode_out_t e;
        logic [63:0] p;
        @(posedge clk);
        #2;
        compare_pending();
        p = take_bits(64);
        instr = w;
        pc    = p;
        wb    = wr;
        e.pc       = p;
        e.instr    = w;
        e.dec      = model_decode(w);
        // reads see the contents before this edge's write
        e.rs1_data = model_regs[e.dec.rs1];
        e.rs2_data = model_regs[e.dec.rs2];
        exp_q.push_back(e);
        name_q.push_back(name);
        if (wr.en && wr.idx != '0)
            model_regs[wr.idx] = wr.data;
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > RESET_WAIT)
                fail_stop("reset was not released within the expected number of cycles");
        end while (reset);
    endtask

    initial begin
        instr_t      w;
        reg_write_t  wr;
        logic [63:0] r;
        reg_idx_t    k;
        int          n_illegal;
        instr = '0;
        pc    = '0;
        wb    = '0;
        lfsr_state = 32'h83cb_b0ff;
        n_illegal  = 0;
        for (int i = 0; i < `NUM_REGS; i++)
            model_regs[i] = '0;

        wait_reset_release();
        check_out("reset_state", '0);

        // fill x1..x31 and read each back on the next word
        for (int i = 1; i < `NUM_REGS; i++) begin
            k  = i[4:0];
            r  = take_bits(64);
            wr = make_write(1'b1, k, r);
            w  = rand_word(1'b0);
            drive_cycle("write_read", w, wr);
            w = r_read_word(k, k);
            drive_cycle("write_read", w, '0);
        end

        // x0 writes dropped and reads stay zero
        for (int i = 0; i < 8; i++) begin
            r  = take_bits(64);
            wr = make_write(1'b1, '0, r);
            w  = r_read_word('0, '0);
            drive_cycle("x0_fixed", w, wr);
            w = r_read_word('0, '0);
            drive_cycle("x0_fixed", w, '0);
        end

        // legal words with random writeback traffic
        for (int i = 0; i < 2000; i++) begin
            w  = rand_word(1'b0);
            r  = take_bits(6);
            wr = make_write(r[5], r[4:0], take_bits(64));
            drive_cycle("field_decode", w, wr);
        end

        // mix with illegal opcodes
        for (int i = 0; i < 400; i++) begin
            w = rand_word(1'b1);
            if (!is_legal_opcode(w[6:0]))
                n_illegal++;
            r  = take_bits(6);
            wr = make_write(r[5], r[4:0], take_bits(64));
            drive_cycle("illegal_opcode", w, wr);
        end
        if (n_illegal == 0)
            fail_stop("no illegal opcode was generated in the illegal phase");

        // same-edge write returns old data and the next word sees the new one
        for (int i = 0; i < 31; i++) begin
            r = take_bits(5);
            k = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
            r  = take_bits(64);
            wr = make_write(1'b1, k, r);
            w  = r_read_word(k, k);
            drive_cycle("read_during_write", w, wr);
            w = r_read_word(k, k);
            drive_cycle("read_after_write", w, '0);
        end

        // last word still in flight
        @(posedge clk);
        #2;
        compare_pending();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
rtl/rv_decode_pkg.sv
rtl/instr_field_decoder.sv
rtl/int_register_file.sv
rtl/decode_pipe_reg.sv
rtl/decode_stage.sv
bench/decode_stage_tb.sv

//--- rtl/decode_params.svh
// width and count macros for the decode stage, include wherever a size is needed
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// integer register and datapath width
`define XLEN 64

// number of integer registers, x0 included
`define NUM_REGS 32

// fixed 32-bit instruction word, no compressed forms
`define INSTR_W 32

// register index, log2 of NUM_REGS
`define REG_IDX_W 5

// funct3 on top of the 7-bit opcode
`define OPFUNC_W 10

`endif

//--- rtl/decode_pipe_reg.sv
// output register of the decode stage, holds pc, word and decoded fields for one cycle
`timescale 1ns/100ps

module decode_pipe_reg
    import rv_decode_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  xlen_t    pc,
    input  instr_t   instr,
    input  decoded_t dec_in,
    output xlen_t    pc_q,
    output instr_t   instr_q,
    output decoded_t dec_q
);

    always_ff @(posedge clk) begin
        if (reset) begin
            // all zero, fmt lands on FMT_NONE
            pc_q    <= '0;
            instr_q <= '0;
            dec_q   <= '0;
        end else begin
            pc_q    <= pc;
            instr_q <= instr;
            dec_q   <= dec_in;
        end
    end

    // decoder output for an unknown opcode, seen after the register
    assert property (@(posedge clk) disable iff (reset)
        dec_q.illegal |-> (dec_q.fmt == FMT_NONE) && (dec_q.rd == '0));

    // upper-immediate and jump words never select a source
    assert property (@(posedge clk) disable iff (reset)
        (dec_q.fmt == FMT_U || dec_q.fmt == FMT_J)
            |-> (dec_q.rs1 == '0) && (dec_q.rs2 == '0));

endmodule

//--- rtl/decode_stage.sv
// decode stage top, one cycle from instruction in to decoded bundle with operands out
`timescale 1ns/100ps

module decode_stage
    import rv_decode_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  instr_t      instr,
    input  xlen_t       pc,
    input  reg_write_t  wb,
    output decode_out_t out
);

    // combinational fields of the incoming word
    decoded_t dec_comb;
    // registered parts, all on the same edge
    decoded_t dec_q;
    xlen_t    pc_q;
    instr_t   instr_q;
    xlen_t    rs1_data;
    xlen_t    rs2_data;

    instr_field_decoder u_decoder (
        .instr (instr),
        .dec   (dec_comb)
    );

    // source indexes straight from the decoder, reads registered inside
    int_register_file u_regfile (
        .clk      (clk),
        .reset    (reset),
        .rs1      (dec_comb.rs1),
        .rs2      (dec_comb.rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    decode_pipe_reg u_pipe_reg (
        .clk     (clk),
        .reset   (reset),
        .pc      (pc),
        .instr   (instr),
        .dec_in  (dec_comb),
        .pc_q    (pc_q),
        .instr_q (instr_q),
        .dec_q   (dec_q)
    );

    // join the registered pieces
    assign out = '{pc: pc_q, instr: instr_q, dec: dec_q,
                   rs1_data: rs1_data, rs2_data: rs2_data};

endmodule

//--- rtl/instr_field_decoder.sv
// combinational instruction decoder, feeds register indexes and fields to the decode stage
`timescale 1ns/100ps
`include "decode_params.svh"

module instr_field_decoder
    import rv_decode_pkg::*;
(
    input  instr_t   instr,
    output decoded_t dec
);

    opcode_e     opc;
    logic [2:0]  funct3;
    reg_idx_t    rs1_f;
    reg_idx_t    rs2_f;
    reg_idx_t    rd_f;
    xlen_t       imm_i;
    xlen_t       imm_s;
    xlen_t       imm_b;
    xlen_t       imm_u;
    xlen_t       imm_j;

    // raw fields, same position in every format
    assign opc    = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rs1_f  = instr[19:15];
    assign rs2_f  = instr[24:20];
    assign rd_f   = instr[11:7];

    // immediates, all sign extended from instr[31]
    assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    // branch offset in halfwords
    assign imm_b = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    // upper 20 bits, low 12 zero
    assign imm_u = {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    always_comb begin
        // illegal word unless an opcode below matches
        dec = '0;
        case (opc)
            OPC_OP, OPC_OP_32: begin
                dec.fmt    = FMT_R;
                dec.opfunc = opfunc_t'({funct3, instr[6:0]});
                dec.rs1    = rs1_f;
                dec.rs2    = rs2_f;
                dec.rd     = rd_f;
            end
            // shift immediates keep the whole I value, shamt sits in its low bits
            OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM_32, OPC_MISC_MEM, OPC_SYSTEM: begin
                dec.fmt    = FMT_I;
                dec.opfunc = opfunc_t'({funct3, instr[6:0]});
                dec.rs1    = rs1_f;
                dec.rd     = rd_f;
                dec.imm    = imm_i;
            end
            OPC_STORE: begin
                // bits 11:7 carry imm here, no destination
                dec.fmt    = FMT_S;
                dec.opfunc = opfunc_t'({funct3, instr[6:0]});
                dec.rs1    = rs1_f;
                dec.rs2    = rs2_f;
                dec.imm    = imm_s;
            end
            OPC_BRANCH: begin
                dec.fmt    = FMT_B;
                dec.opfunc = opfunc_t'({funct3, instr[6:0]});
                dec.rs1    = rs1_f;
                dec.rs2    = rs2_f;
                dec.imm    = imm_b;
            end
            OPC_LUI, OPC_AUIPC: begin
                // no funct3 and no sources
                dec.fmt    = FMT_U;
                dec.opfunc = opfunc_t'({3'b000, instr[6:0]});
                dec.rd     = rd_f;
                dec.imm    = imm_u;
            end
            OPC_JAL: begin
                dec.fmt    = FMT_J;
                dec.opfunc = opfunc_t'({3'b000, instr[6:0]});
                dec.rd     = rd_f;
                dec.imm    = imm_j;
            end
            default: begin
                // outside the thirteen major opcodes
                dec.illegal = 1'b1;
            end
        endcase
    end

endmodule

//--- rtl/int_register_file.sv
// integer register file with one write port and two registered reads for the decode stage top
`timescale 1ns/100ps
`include "decode_params.svh"

module int_register_file
    import rv_decode_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  reg_idx_t   rs1,
    input  reg_idx_t   rs2,
    input  reg_write_t wb,
    output xlen_t      rs1_data,
    output xlen_t      rs2_data
);

    xlen_t regs [`NUM_REGS];
    logic  wr_ok;

    // x0 never written so it stays at its reset zero
    assign wr_ok = wb.en && (wb.idx != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            // every entry cleared including x2
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            rs1_data <= '0;
            rs2_data <= '0;
        end else begin
            // reads see the old contents on a same-edge write
            rs1_data <= regs[rs1];
            rs2_data <= regs[rs2];
            if (wr_ok) begin
                regs[wb.idx] <= wb.data;
            end
        end
    end

    // a read of x0 gives zero on the next cycle
    assert property (@(posedge clk) disable iff (reset)
        (rs1 == '0) |=> (rs1_data == '0));

    // first reads after reset see the cleared array
    assert property (@(posedge clk)
        $fell(reset) |=> (rs1_data == '0) && (rs2_data == '0));

endmodule

//--- rtl/rv_decode_pkg.sv
// shared types of the decode stage, import with rv_decode_pkg::* in a module header
`include "decode_params.svh"

package rv_decode_pkg;

    // plain vectors with a meaning
    typedef logic [`XLEN-1:0]      xlen_t;
    typedef logic [`INSTR_W-1:0]   instr_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`OPFUNC_W-1:0]  opfunc_t;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP        = 7'b0110011,
        OPC_OP_32     = 7'b0111011,
        OPC_JALR      = 7'b1100111,
        OPC_LOAD      = 7'b0000011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_STORE     = 7'b0100011,
        OPC_BRANCH    = 7'b1100011,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_MISC_MEM  = 7'b0001111,
        OPC_SYSTEM    = 7'b1110011
    } opcode_e;

    // encoding format, none for illegal words and after reset
    typedef enum logic [2:0] {
        FMT_NONE = 3'd0,
        FMT_R    = 3'd1,
        FMT_I    = 3'd2,
        FMT_S    = 3'd3,
        FMT_B    = 3'd4,
        FMT_U    = 3'd5,
        FMT_J    = 3'd6
    } instr_fmt_e;

    // writeback port into the register file
    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        xlen_t    data;
    } reg_write_t;

    // fields pulled out of one instruction word
    typedef struct packed {
        instr_fmt_e fmt;
        opfunc_t    opfunc;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        xlen_t      imm;
        logic       illegal;
    } decoded_t;

    // everything handed to the execute stage
    typedef struct packed {
        xlen_t    pc;
        instr_t   instr;
        decoded_t dec;
        xlen_t    rs1_data;
        xlen_t    rs2_data;
    } decode_out_t;

endpackage
